//--- Makefile
.PHONY: help test clean

help:
	@echo "test   build with Verilator, run the testbench, log in sim.log"
	@echo "clean  remove obj_dir and sim.log"
	@echo "help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module arithEncoderTb -f build.f -o simv
	./obj_dir/simv > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- build.f
logic/codecParamPkg.sv
logic/codecStatePkg.sv
logic/codecIfs.sv
logic/freqModel.sv
logic/intervalDivider.sv
logic/bitPacker.sv
logic/intervalCoder.sv
logic/arithEncoder.sv
verif/arithEncoder_assert.sv
verif/arithEncoderTb.sv

//--- logic/arithEncoder.sv
// encoder top; symbols arrive by the newBitsRequested handshake, words leave by the resultReady handshake
`timescale 1ns/1ps

module arithEncoder (
    input logic clk,
    input logic rstn,
    input logic start,
    input logic readSuccess,
    input logic newBitsProvided,
    input logic [codecParamPkg::SYM_W-1:0] inputBits,
    output logic idle,
    output logic resultReady,
    output logic newBitsRequested,
    output logic [2:0] validOutputBytes,
    output logic [codecParamPkg::OUT_W-1:0] out
);

    divIf divBus ();
    modelIf modelBus ();
    bitIf bitBus ();

    intervalCoder coder (
        .clk(clk),
        .rstn(rstn),
        .start(start),
        .newBitsProvided(newBitsProvided),
        .inputBits(inputBits),
        .idle(idle),
        .newBitsRequested(newBitsRequested),
        .div(divBus.requester),
        .model(modelBus.coder),
        .bits(bitBus.source)
    );

    freqModel model (
        .clk(clk),
        .rstn(rstn),
        .model(modelBus.freqTable)
    );

    intervalDivider divider (
        .clk(clk),
        .rstn(rstn),
        .div(divBus.server)
    );

    bitPacker packer (
        .clk(clk),
        .rstn(rstn),
        .readSuccess(readSuccess),
        .bits(bitBus.sink),
        .resultReady(resultReady),
        .validOutputBytes(validOutputBytes),
        .out(out)
    );

endmodule

//--- logic/bitPacker.sv
// packs code bits LSB first into OUT_W-bit words; no bits are taken until readSuccess has dropped
`timescale 1ns/1ps

module bitPacker (
    input logic clk,
    input logic rstn,
    input logic readSuccess,
    bitIf.sink bits,
    output logic resultReady,
    output logic [2:0] validOutputBytes,
    output logic [codecParamPkg::OUT_W-1:0] out
);
    import codecParamPkg::*;
    import codecStatePkg::*;

    packState_t state;
    logic [BITPOS_W-1:0] bitPos;

    assign bits.busy = (state != PACK_FILL);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= PACK_FILL;
            bitPos <= '0;
            resultReady <= 1'b0;
            validOutputBytes <= 3'd0;
            out <= '0;
        end else begin
            case (state)
                PACK_FILL: begin
                    if (bits.valid) begin
                        out[bitPos] <= bits.codeBit;
                        if (bits.last || bitPos == BITPOS_W'(OUT_W - 1)) begin
                            resultReady <= 1'b1;        // word full or stream closed
                            validOutputBytes <= bits.last ? bits.lastBytes : 3'(OUT_W / 8);
                            state <= PACK_WAIT_READ;
                        end else begin
                            bitPos <= bitPos + 1'b1;
                        end
                    end
                end
                PACK_WAIT_READ: begin
                    if (readSuccess) begin
                        resultReady <= 1'b0;
                        out <= '0;
                        bitPos <= '0;
                        state <= PACK_WAIT_RELEASE;
                    end
                end
                PACK_WAIT_RELEASE: begin
                    if (!readSuccess) begin
                        state <= PACK_FILL;             // busy drops on the next cycle
                    end
                end
                default: begin
                    state <= PACK_FILL;
                end
            endcase
        end
    end

endmodule

//--- logic/codecIfs.sv
// internal buses of the encoder; modports are named from the point of view of each side
`timescale 1ns/1ps

// start is a one-cycle pulse, done follows exactly DIV_CYCLES cycles later
interface divIf;
    logic start;
    logic [codecParamPkg::PROD_W-1:0] dividend;
    logic [codecParamPkg::FREQ_W-1:0] divisor;
    logic done;
    logic [codecParamPkg::PRECISION-1:0] quotient;

    modport requester (output start, output dividend, output divisor,
                       input done, input quotient);
    modport server (input start, input dividend, input divisor,
                    output done, output quotient);
endinterface

// lookup is combinational, update and clear land on the next edge
interface modelIf;
    logic [codecParamPkg::SYM_W-1:0] symbol;
    logic [codecParamPkg::FREQ_W-1:0] cumLow;
    logic [codecParamPkg::FREQ_W-1:0] cumHigh;
    logic [codecParamPkg::FREQ_W-1:0] total;
    logic update;
    logic clear;

    modport coder (output symbol, output update, output clear,
                   input cumLow, input cumHigh, input total);
    modport freqTable (input symbol, input update, input clear,
                       output cumLow, output cumHigh, output total);
endinterface

// a bit moves when valid is high and busy is low
interface bitIf;
    logic valid;
    logic codeBit;
    logic last;
    logic [2:0] lastBytes;
    logic busy;

    modport source (output valid, output codeBit, output last, output lastBytes,
                    input busy);
    modport sink (input valid, input codeBit, input last, input lastBytes,
                  output busy);
endinterface

//--- logic/codecParamPkg.sv
// coder constants; fixed 32-bit precision and 17-symbol alphabet, no frequency halving so total must stay below QUARTER
package codecParamPkg;

    localparam int PRECISION = 32;                 // width of the interval bounds
    localparam int NUM_SYMBOLS = 17;               // 16 data symbols plus end of stream
    localparam int EOF_SYMBOL = 16;
    localparam int SYM_W = $clog2(NUM_SYMBOLS);
    localparam int FREQ_W = PRECISION - 3;         // counts stay below a quarter of the range

    localparam logic [PRECISION-1:0] WHOLE = PRECISION'(1) << (PRECISION - 1);
    localparam logic [PRECISION-1:0] HALF = PRECISION'(1) << (PRECISION - 2);
    localparam logic [PRECISION-1:0] QUARTER = PRECISION'(1) << (PRECISION - 3);
    localparam logic [PRECISION-1:0] THREE_QUARTERS = PRECISION'(3) << (PRECISION - 3);

    // width times cumulative frequency, dividend of the divider
    localparam int PROD_W = PRECISION + FREQ_W;

    localparam int OUT_W = 32;                     // packed output word
    localparam int BITPOS_W = $clog2(OUT_W);       // bit index inside a word

    localparam int DIV_CYCLES = PRECISION;         // one quotient bit per cycle
    localparam int DIV_CNT_W = $clog2(DIV_CYCLES);

endpackage

//--- logic/codecStatePkg.sv
// state encodings of the interval coder and bit packer FSMs; values carry no external meaning
package codecStatePkg;

    typedef enum logic [3:0] {
        CODER_IDLE,
        CODER_MUL,          // form products, launch upper bound division
        CODER_DIV_HIGH,     // wait for new b
        CODER_DIV_LOW,      // wait for new a
        CODER_RESCALE,
        CODER_EMIT,         // rescale bit or final bit
        CODER_PENDING,      // opposite bits owed to middle rescales
        CODER_REQUEST,      // newBitsRequested open
        CODER_RELEASE,      // wait for newBitsProvided to drop
        CODER_DRAIN         // last word still in the packer
    } coderState_t;

    typedef enum logic [1:0] {
        PACK_FILL,
        PACK_WAIT_READ,
        PACK_WAIT_RELEASE
    } packState_t;

endpackage

//--- logic/freqModel.sv
// adaptive cumulative frequency table; symbol must be below NUM_SYMBOLS, counts never halve
`timescale 1ns/1ps

module freqModel (
    input logic clk,
    input logic rstn,
    modelIf.freqTable model
);
    import codecParamPkg::*;

    logic [FREQ_W-1:0] cumLowTab [NUM_SYMBOLS];
    logic [FREQ_W-1:0] cumHighTab [NUM_SYMBOLS];
    logic [FREQ_W-1:0] totalReg;

    assign model.cumLow = cumLowTab[model.symbol];      // combinational lookup
    assign model.cumHigh = cumHighTab[model.symbol];
    assign model.total = totalReg;

    always_ff @(posedge clk) begin
        if (!rstn || model.clear) begin
            // every symbol starts with count 1
            for (int i = 0; i < NUM_SYMBOLS; i++) begin
                cumLowTab[i] <= FREQ_W'(i);
                cumHighTab[i] <= FREQ_W'(i + 1);
            end
            totalReg <= FREQ_W'(NUM_SYMBOLS);
        end else if (model.update) begin
            for (int i = 0; i < NUM_SYMBOLS; i++) begin
                if (SYM_W'(i) > model.symbol) begin
                    cumLowTab[i] <= cumLowTab[i] + 1'b1;     // whole slot moves up
                    cumHighTab[i] <= cumHighTab[i] + 1'b1;
                end else if (SYM_W'(i) == model.symbol) begin
                    cumHighTab[i] <= cumHighTab[i] + 1'b1;   // coded symbol widens
                end
            end
            totalReg <= totalReg + 1'b1;
        end
    end

endmodule

//--- logic/intervalCoder.sv
// encoder FSM; expects symbols below NUM_SYMBOLS and a stream closed by EOF_SYMBOL, start only sampled while idle
`timescale 1ns/1ps

module intervalCoder (
    input logic clk,
    input logic rstn,
    input logic start,
    input logic newBitsProvided,
    input logic [codecParamPkg::SYM_W-1:0] inputBits,
    output logic idle,
    output logic newBitsRequested,
    divIf.requester div,
    modelIf.coder model,
    bitIf.source bits
);
    import codecParamPkg::*;
    import codecStatePkg::*;

    coderState_t state;

    logic [PRECISION-1:0] a;
    logic [PRECISION-1:0] b;
    logic [PRECISION-1:0] w;
    logic [PRECISION-1:0] s;                // pending opposite bits
    logic [SYM_W-1:0] symbol;
    logic [BITPOS_W-1:0] bitCnt;            // mirrors the packer's position
    logic [PROD_W-1:0] prodLow;
    logic emitBit;
    logic finalBits;                        // end-of-stream tail is being sent

    assign model.symbol = symbol;
    assign model.clear = (state == CODER_IDLE) && start;   // fresh table per stream
    assign div.divisor = model.total;

    assign bits.valid = (state == CODER_EMIT) || (state == CODER_PENDING);
    assign bits.codeBit = (state == CODER_PENDING) ? ~emitBit : emitBit;
    assign bits.last = finalBits && (state == CODER_PENDING) && (s == PRECISION'(1));
    assign bits.lastBytes = 3'(bitCnt >> 3) + 3'd1;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= CODER_IDLE;
            idle <= 1'b1;
            newBitsRequested <= 1'b0;
            finalBits <= 1'b0;
            div.start <= 1'b0;
            model.update <= 1'b0;
        end else begin
            div.start <= 1'b0;
            model.update <= 1'b0;
            case (state)
                CODER_IDLE: begin
                    if (start) begin
                        symbol <= inputBits;            // first symbol rides on start
                        a <= '0;
                        b <= WHOLE;
                        w <= WHOLE;
                        s <= '0;
                        bitCnt <= '0;
                        finalBits <= 1'b0;
                        idle <= 1'b0;
                        state <= CODER_MUL;
                    end
                end
                CODER_MUL: begin
                    div.dividend <= w * model.cumHigh;
                    prodLow <= w * model.cumLow;
                    div.start <= 1'b1;
                    state <= CODER_DIV_HIGH;
                end
                CODER_DIV_HIGH: begin
                    if (div.done) begin
                        b <= a + div.quotient;          // uses a before it moves
                        div.dividend <= prodLow;
                        div.start <= 1'b1;
                        state <= CODER_DIV_LOW;
                    end
                end
                CODER_DIV_LOW: begin
                    if (div.done) begin
                        a <= a + div.quotient;
                        state <= CODER_RESCALE;
                    end
                end
                CODER_RESCALE: begin
                    if (b < HALF) begin
                        a <= a << 1;                    // left half
                        b <= b << 1;
                        emitBit <= 1'b0;
                        state <= CODER_EMIT;
                    end else if (a > HALF) begin
                        a <= (a - HALF) << 1;           // right half
                        b <= (b - HALF) << 1;
                        emitBit <= 1'b1;
                        state <= CODER_EMIT;
                    end else if (a > QUARTER && b < THREE_QUARTERS) begin
                        a <= (a - QUARTER) << 1;        // middle, bit decided later
                        b <= (b - QUARTER) << 1;
                        s <= s + 1'b1;
                    end else if (symbol == SYM_W'(EOF_SYMBOL)) begin
                        // final bit picks the quarter that lies inside [a, b)
                        emitBit <= (a > QUARTER);
                        s <= s + 1'b1;
                        finalBits <= 1'b1;
                        state <= CODER_EMIT;
                    end else if (!bits.busy) begin
                        w <= b - a;                     // no request while a word is on offer
                        model.update <= 1'b1;
                        newBitsRequested <= 1'b1;
                        state <= CODER_REQUEST;
                    end
                end
                CODER_EMIT: begin
                    if (!bits.busy) begin
                        bitCnt <= bitCnt + 1'b1;
                        state <= (s != '0) ? CODER_PENDING : CODER_RESCALE;
                    end
                end
                CODER_PENDING: begin
                    if (!bits.busy) begin
                        bitCnt <= bitCnt + 1'b1;
                        s <= s - 1'b1;
                        if (s == PRECISION'(1)) begin
                            state <= finalBits ? CODER_DRAIN : CODER_RESCALE;
                        end
                    end
                end
                CODER_REQUEST: begin
                    if (newBitsProvided) begin
                        newBitsRequested <= 1'b0;
                        symbol <= inputBits;
                        state <= CODER_RELEASE;
                    end
                end
                CODER_RELEASE: begin
                    if (!newBitsProvided) begin
                        state <= CODER_MUL;
                    end
                end
                CODER_DRAIN: begin
                    if (!bits.busy) begin               // final word has been read
                        idle <= 1'b1;
                        state <= CODER_IDLE;
                    end
                end
                default: begin
                    state <= CODER_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/intervalDivider.sv
// restoring serial divider; quotient must fit PRECISION bits, i.e. dividend < divisor << PRECISION
`timescale 1ns/1ps

module intervalDivider (
    input logic clk,
    input logic rstn,
    divIf.server div
);
    import codecParamPkg::*;

    logic [FREQ_W-1:0] rem;
    logic [PRECISION-1:0] quo;              // low dividend bits out, quotient bits in
    logic [FREQ_W-1:0] divisorReg;
    logic [DIV_CNT_W-1:0] cyclesLeft;

    logic [FREQ_W-1:0] remIn;
    logic [PRECISION-1:0] quoIn;
    logic [FREQ_W-1:0] divisorIn;
    logic [FREQ_W:0] trial;
    logic [FREQ_W:0] diff;
    logic fits;

    // the first step runs on the start edge straight from the operands
    always_comb begin
        remIn = div.start ? div.dividend[PROD_W-1:PRECISION] : rem;
        quoIn = div.start ? div.dividend[PRECISION-1:0] : quo;
        divisorIn = div.start ? div.divisor : divisorReg;
        trial = {remIn, quoIn[PRECISION-1]};
        diff = trial - {1'b0, divisorIn};
        fits = (trial >= {1'b0, divisorIn});
    end

    assign div.quotient = quo;

    always_ff @(posedge clk) begin
        if (div.start || cyclesLeft != '0) begin
            rem <= fits ? diff[FREQ_W-1:0] : trial[FREQ_W-1:0];
            quo <= {quoIn[PRECISION-2:0], fits};
            divisorReg <= divisorIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cyclesLeft <= '0;
            div.done <= 1'b0;
        end else begin
            div.done <= 1'b0;
            if (div.start) begin
                cyclesLeft <= DIV_CNT_W'(DIV_CYCLES - 1);
            end else if (cyclesLeft != '0) begin
                cyclesLeft <= cyclesLeft - 1'b1;
                if (cyclesLeft == DIV_CNT_W'(1)) begin
                    div.done <= 1'b1;               // last quotient bit lands with this edge
                end
            end
        end
    end

endmodule

//--- verif/arithEncoderTb.sv
// file-driven encoder testbench; expects verif/encoder_stimulus.txt run from the project root, at most 16 tests
`timescale 1ns/1ps

module arithEncoderTb;
    import codecParamPkg::*;

    localparam int MAX_TESTS = 16;
    localparam int CLK_HALF = 4;                    // 8 ns period
    localparam int RESET_CYCLES = 8;

    logic clk;
    logic rstn;
    logic start;
    logic readSuccess;
    logic newBitsProvided;
    logic [SYM_W-1:0] inputBits;
    logic idle;
    logic resultReady;
    logic newBitsRequested;
    logic [2:0] validOutputBytes;
    logic [OUT_W-1:0] out;

    int numTests;
    int testNum [MAX_TESTS];
    int readDelay [MAX_TESTS];
    int symFirst [MAX_TESTS];
    int symCnt [MAX_TESTS];
    int fileFirst [MAX_TESTS];
    int fileCnt [MAX_TESTS];
    int fileVob [MAX_TESTS];
    int refFirst [MAX_TESTS];
    int refCnt [MAX_TESTS];
    int refVob [MAX_TESTS];
    int symAll [$];
    logic [31:0] fileWords [$];
    logic [31:0] refWords [$];
    logic [31:0] gotWords [$];
    logic [31:0] prevWords [$];
    logic [2:0] gotVob [$];
    bit codeBits [$];
    int errors;
    int checks;
    int failedTests;
    int cycleCount;
    int cycleLimit;
    bit limitSet;
    int unsigned seedVal;

    arithEncoder dut (
        .clk(clk),
        .rstn(rstn),
        .start(start),
        .readSuccess(readSuccess),
        .newBitsProvided(newBitsProvided),
        .inputBits(inputBits),
        .idle(idle),
        .resultReady(resultReady),
        .newBitsRequested(newBitsRequested),
        .validOutputBytes(validOutputBytes),
        .out(out)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (limitSet && cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // inputs change 1 ns after the edge, outputs are read there too
    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic loadStimulus();
        int fd;
        int code;
        int v;
        int n;
        logic [31:0] word;
        string line;
        fd = $fopen("verif/encoder_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/encoder_stimulus.txt");
            errors++;
            return;
        end
        code = $fgets(line, fd);                    // two column description lines
        code = $fgets(line, fd);
        numTests = 0;
        while (numTests < MAX_TESTS && $fscanf(fd, "%d", v) == 1) begin
            testNum[numTests] = v;
            code = $fscanf(fd, "%d", v);
            readDelay[numTests] = v;
            symFirst[numTests] = symAll.size();
            symCnt[numTests] = 0;
            do begin
                code = $fscanf(fd, "%d", v);
                symAll.push_back(v);
                symCnt[numTests]++;
            end while (code == 1 && v != EOF_SYMBOL);
            code = $fscanf(fd, "%d", n);
            fileFirst[numTests] = fileWords.size();
            fileCnt[numTests] = n;
            for (int i = 0; i < n; i++) begin
                code = $fscanf(fd, "%h", word);
                fileWords.push_back(word);
            end
            code = $fscanf(fd, "%d", v);
            fileVob[numTests] = v;
            numTests++;
        end
        $fclose(fd);
    endtask

    // one code bit followed by the owed opposite bits
    task automatic putBit(input bit v, inout longint unsigned pend);
        codeBits.push_back(v);
        while (pend > 0) begin
            codeBits.push_back(!v);
            pend--;
        end
    endtask

    // adaptive model and interval rules, 64-bit arithmetic
    task automatic modelStream(input int t);
        longint unsigned a;
        longint unsigned b;
        longint unsigned w;
        longint unsigned pend;
        longint unsigned lo;
        longint unsigned hi;
        longint unsigned tot;
        longint unsigned half;
        longint unsigned quarter;
        int cnt [NUM_SYMBOLS];
        int sym;
        int nBits;
        logic [31:0] word;
        codeBits.delete();
        half = 64'd1 << 30;
        quarter = 64'd1 << 29;
        for (int i = 0; i < NUM_SYMBOLS; i++) cnt[i] = 1;
        tot = NUM_SYMBOLS;
        a = 0;
        b = 64'd1 << 31;
        w = b;
        pend = 0;
        for (int k = 0; k < symCnt[t]; k++) begin
            sym = symAll[symFirst[t] + k];
            lo = 0;
            for (int i = 0; i < sym; i++) lo += cnt[i];
            hi = lo + cnt[sym];
            b = a + w * hi / tot;
            a = a + w * lo / tot;
            while (1) begin
                if (b < half) begin
                    a = a * 2;
                    b = b * 2;
                    putBit(1'b0, pend);
                end else if (a > half) begin
                    a = (a - half) * 2;
                    b = (b - half) * 2;
                    putBit(1'b1, pend);
                end else if (a > quarter && b < 3 * quarter) begin
                    a = (a - quarter) * 2;
                    b = (b - quarter) * 2;
                    pend++;
                end else begin
                    break;
                end
            end
            if (sym == EOF_SYMBOL) begin
                pend++;
                putBit(a > quarter, pend);
                break;
            end
            w = b - a;
            cnt[sym]++;
            tot++;
        end
        refFirst[t] = refWords.size();
        word = '0;
        nBits = codeBits.size();
        for (int i = 0; i < nBits; i++) begin
            word[i % 32] = codeBits[i];             // LSB first
            if (i % 32 == 31 || i == nBits - 1) begin
                refWords.push_back(word);
                word = '0;
            end
        end
        refCnt[t] = refWords.size() - refFirst[t];
        refVob[t] = ((nBits - 1) % 32) / 8 + 1;
    endtask

    task automatic feedSymbols(input int t);
        bit sawRequest;
        for (int k = 1; k < symCnt[t]; k++) begin
            while (!newBitsRequested) stepCycle();
            inputBits = SYM_W'(symAll[symFirst[t] + k]);
            newBitsProvided = 1'b1;
            stepCycle();
            while (newBitsRequested) stepCycle();
            newBitsProvided = 1'b0;
            stepCycle();
        end
        sawRequest = 1'b0;
        while (!idle) begin
            if (newBitsRequested) sawRequest = 1'b1;
            stepCycle();
        end
        checks++;
        assert (!sawRequest) else begin
            $display("** Error at %0t: symbol requested after end of stream", $time);
            errors++;
        end
    endtask

    task automatic collectWords(input int t);
        logic [OUT_W-1:0] held;
        int pause;
        while (!idle) begin
            if (resultReady) begin
                held = out;
                gotWords.push_back(out);
                gotVob.push_back(validOutputBytes);
                pause = readDelay[t] + int'($urandom % 4);
                repeat (pause) begin
                    stepCycle();
                    checks++;
                    assert (resultReady && out == held) else begin
                        $display("** Error at %0t: word changed while waiting for read", $time);
                        errors++;
                    end
                end
                readSuccess = 1'b1;
                stepCycle();
                while (resultReady) stepCycle();
                readSuccess = 1'b0;
            end
            stepCycle();
        end
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string src);
        checks++;
        assert (got == exp) else begin
            $display("** Error at %0t: word %h, %s expects %h", $time, got, src, exp);
            errors++;
        end
    endtask

    task automatic runTest(input int t);
        int errBefore;
        int last;
        bit sameSyms;
        errBefore = errors;
        gotWords.delete();
        gotVob.delete();
        while (!idle) stepCycle();
        inputBits = SYM_W'(symAll[symFirst[t]]);
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        fork
            feedSymbols(t);
            collectWords(t);
        join
        checks++;
        assert (gotWords.size() == refCnt[t]) else begin
            $display("** Error at %0t: %0d words, expected %0d", $time,
                     gotWords.size(), refCnt[t]);
            errors++;
        end
        last = gotWords.size() - 1;
        for (int i = 0; i <= last && i < refCnt[t]; i++) begin
            checkWord(gotWords[i], refWords[refFirst[t] + i], "model");
            checks++;
            assert (gotVob[i] == ((i == last) ? 3'(refVob[t]) : 3'd4)) else begin
                $display("** Error at %0t: validOutputBytes %0d on word %0d", $time, gotVob[i], i);
                errors++;
            end
        end
        if (fileCnt[t] > 0) begin
            checks++;
            assert (gotWords.size() == fileCnt[t] && last >= 0 && gotVob[last] == 3'(fileVob[t]))
            else begin
                $display("** Error at %0t: word count or final length differs from file", $time);
                errors++;
            end
            for (int i = 0; i < fileCnt[t] && i <= last; i++) begin
                checkWord(gotWords[i], fileWords[fileFirst[t] + i], "file");
            end
        end
        sameSyms = (t > 0) && (symCnt[t] == symCnt[t - 1]);
        for (int i = 0; sameSyms && i < symCnt[t]; i++) begin
            if (symAll[symFirst[t] + i] != symAll[symFirst[t - 1] + i]) sameSyms = 1'b0;
        end
        if (sameSyms) begin
            checks++;
            assert (gotWords == prevWords) else begin
                $display("** Error at %0t: words differ from the previous run", $time);
                errors++;
            end
        end
        prevWords = gotWords;
        if (errors != errBefore) failedTests++;
        $display("test %0d: %s, %0d words, read delay %0d", testNum[t],
                 (errors == errBefore) ? "ok" : "mismatch", gotWords.size(), readDelay[t]);
    endtask

    initial begin
        seedVal = $urandom(32'haff84f0a);
        rstn = 1'b0;
        start = 1'b0;
        readSuccess = 1'b0;
        newBitsProvided = 1'b0;
        inputBits = '0;
        errors = 0;
        checks = 0;
        failedTests = 0;
        cycleCount = 0;
        limitSet = 1'b0;
        loadStimulus();
        if (numTests == 0) begin
            $display("no tests were read from the stimulus file");
            errors++;
        end
        for (int t = 0; t < numTests; t++) modelStream(t);
        cycleLimit = 300 * symAll.size() + 200 * refWords.size() + 1000 + RESET_CYCLES;
        limitSet = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        checks++;
        assert (idle && !resultReady && !newBitsRequested && out == '0) else begin
            $display("** Error at %0t: outputs not in reset state", $time);
            errors++;
        end
        rstn = 1'b1;
        stepCycle();
        for (int t = 0; t < numTests; t++) runTest(t);
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 numTests, failedTests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verif/arithEncoder_assert.sv
// handshake rules on the encoder top, bound to every arithEncoder instance
`timescale 1ns/1ps

module arithEncoderAssert (
    input logic clk,
    input logic rstn,
    input logic readSuccess,
    input logic idle,
    input logic resultReady,
    input logic newBitsRequested,
    input logic [codecParamPkg::OUT_W-1:0] out
);

    holdReady: assert property (@(posedge clk) disable iff (!rstn)
        resultReady && !readSuccess |=> resultReady)
        else $error("resultReady dropped before readSuccess");

    // symbol request and word offer never overlap
    noOverlap: assert property (@(posedge clk) disable iff (!rstn)
        !(resultReady && newBitsRequested))
        else $error("newBitsRequested and resultReady high together");

    stableOut: assert property (@(posedge clk) disable iff (!rstn)
        resultReady && !readSuccess |=> $stable(out))
        else $error("out changed while resultReady was high");

    resetState: assert property (@(posedge clk)
        !rstn |=> idle && !resultReady)
        else $error("idle or resultReady wrong after reset");

endmodule

bind arithEncoder arithEncoderAssert handshakeChecks (
    .clk(clk),
    .rstn(rstn),
    .readSuccess(readSuccess),
    .idle(idle),
    .resultReady(resultReady),
    .newBitsRequested(newBitsRequested),
    .out(out)
);

//--- verif/encoder_stimulus.txt
# columns: test readDelay symbols...(closed by 16) wordCount words(hex)... finalValidBytes
# wordCount 0 and finalValidBytes 0 leave the expected words to the testbench reference model
1 2 16 1 0000002f 1
2 1 3 3 7 0 15 3 12 3 3 9 1 3 5 3 3 14 2 3 3 8 3 11 0 3 3 6 3 3 15 4 3 10 3 3 13 3 3 3 16 0 0
3 25 3 3 7 0 15 3 12 3 3 9 1 3 5 3 3 14 2 3 3 8 3 11 0 3 3 6 3 3 15 4 3 10 3 3 13 3 3 3 16 0 0
4 1 3 3 7 0 15 3 12 3 3 9 1 3 5 3 3 14 2 3 3 8 3 11 0 3 3 6 3 3 15 4 3 10 3 3 13 3 3 3 16 0 0
5 0 5 5 5 5 5 5 5 5 5 5 16 0 0
6 3 16 1 0000002f 1
